//--- hw/hififo_pkg.sv
package hififo_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Data types
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Word carried on both streams and in PIO writes.
   typedef logic [63:0] word_t;

   // One host register write, as seen on the PIO channel.
   typedef struct packed {
      logic        valid;
      logic [12:0] address;
      word_t       data;
   } pio_write_t;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Register map
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Full data word becomes the counter start value.
   localparam logic [12:0] REG_COUNT_LOAD = 13'd14;

   // Data bit 0 selects the mode, 1 is count, 0 is loopback.
   localparam logic [12:0] REG_MODE = 13'd15;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Sizes and reset values
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // From-host FIFO depth.
   localparam int FPC_DEPTH = 16;

   // To-host FIFO depth.
   localparam int TPC_DEPTH = 8;

   // LED pattern after reset.
   localparam logic [3:0] LED_RESET = 4'h5;

endpackage

//--- hw/sync_fifo.sv
`timescale 1ns/1ns

// Single-clock FIFO, first word falls through to rd_data.
// DEPTH must be a power of two, 2 or more.
module sync_fifo
  #(
   parameter int DEPTH = 2
   )
  (
   input  logic              clock,
   input  logic              reset,
   input  hififo_pkg::word_t wr_data,
   input  logic              wr_en,
   output logic              ready,
   output hififo_pkg::word_t rd_data,
   output logic              valid,
   input  logic              rd_en
   );

   import hififo_pkg::*;

   localparam int          AW         = $clog2(DEPTH);
   localparam logic [AW:0] FULL_COUNT = (AW + 1)'(DEPTH);

   word_t         mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic          push;
   logic          pop;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Handshake
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // A write at full or a read at empty is simply not taken.
   assign push = wr_en && ready;
   assign pop  = rd_en && valid;

   assign ready = (count != FULL_COUNT);
   assign valid = (count != '0);

   // Head word, visible as soon as it is stored.
   assign rd_data = mem[rd_ptr];

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Storage
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clock)
   begin
      if (push)
         mem[wr_ptr] <= wr_data;
   end

   // Pointers wrap on their own, DEPTH being a power of two.
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // Occupancy. Push and pop together leave it unchanged.
   always_ff @(posedge clock)
   begin
      if (reset)
         count <= '0;
      else
      begin
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

//--- hw/pio_regs.sv
`timescale 1ns/1ns

// Host register decode: mode bit and counter load.
module pio_regs
  (
   input  logic                   clock,
   input  logic                   reset,
   input  hififo_pkg::pio_write_t pio,
   output logic                   count_mode,
   output logic                   count_load,
   output hififo_pkg::word_t      count_value
   );

   import hififo_pkg::*;

   logic mode_hit;
   logic load_hit;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Address match
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Anything outside the map falls through both.
   assign mode_hit = pio.valid && (pio.address == REG_MODE);
   assign load_hit = pio.valid && (pio.address == REG_COUNT_LOAD);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Registers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Count mode out of reset.
   always_ff @(posedge clock)
   begin
      if (reset)
         count_mode <= 1'b1;
      else if (mode_hit)
         count_mode <= pio.data[0];
   end

   // One-cycle load strobe.
   always_ff @(posedge clock)
   begin
      if (reset)
         count_load <= 1'b0;
      else
         count_load <= load_hit;
   end

   // Start value, valid alongside the strobe.
   always_ff @(posedge clock)
   begin
      if (load_hit)
         count_value <= pio.data;
   end

endmodule

//--- hw/fifo_app.sv
`timescale 1ns/1ns

// One-word producer stage between the two FIFOs.
// Loops from-host words or emits a running counter.
module fifo_app
  (
   input  logic              clock,
   input  logic              reset,
   input  logic              count_mode,
   input  logic              count_load,
   input  hififo_pkg::word_t count_value,
   input  hififo_pkg::word_t src_data,
   input  logic              src_valid,
   output logic              src_read,
   output hififo_pkg::word_t out_data,
   output logic              out_write,
   input  logic              out_ready,
   output logic [3:0]        led
   );

   import hififo_pkg::*;

   word_t counter;
   logic  load_en;

   // Register is empty, or its word is taken this cycle.
   assign load_en = !out_write || out_ready;

   // Pop only when the looped word goes into the register.
   assign src_read = !count_mode && load_en && src_valid;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Counter
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // A host load wins over the increment.
   always_ff @(posedge clock)
   begin
      if (reset)
         counter <= '0;
      else if (count_load)
         counter <= count_value;
      else if (count_mode && load_en)
         counter <= counter + 64'd1;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Output register
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clock)
   begin
      if (reset)
         out_write <= 1'b0;
      else if (load_en)
      begin
         if (count_mode)
            out_write <= 1'b1;
         else
            out_write <= src_valid;
      end
   end

   always_ff @(posedge clock)
   begin
      if (load_en)
      begin
         if (count_mode)
            out_data <= counter;
         else if (src_valid)
            out_data <= src_data;
      end
   end

   // Low nibble of the last looped word.
   always_ff @(posedge clock)
   begin
      if (reset)
         led <= LED_RESET;
      else if (src_read)
         led <= src_data[3:0];
   end

endmodule

//--- hw/fifo_bridge_top.sv
`timescale 1ns/1ns

// Fabric side of the host FIFO example.
// PIO decode, from-host FIFO, application, to-host FIFO.
module fifo_bridge_top
  (
   input  logic                   clock,
   input  logic                   reset,
   input  hififo_pkg::pio_write_t pio,
   input  hififo_pkg::word_t      fpc_data,
   input  logic                   fpc_write,
   output logic                   fpc_ready,
   output hififo_pkg::word_t      tpc_data,
   output logic                   tpc_valid,
   input  logic                   tpc_read,
   output logic [3:0]             led
   );

   import hififo_pkg::*;

   // Mode and counter control.
   logic  count_mode;
   logic  count_load;
   word_t count_value;

   // From-host FIFO read side.
   word_t fpc_head;
   logic  fpc_head_valid;
   logic  fpc_pop;

   // Application output into the to-host FIFO.
   word_t app_data;
   logic  app_write;
   logic  app_ready;

   pio_regs pio_regs_i
     (.clock       (clock),
      .reset       (reset),
      .pio         (pio),
      .count_mode  (count_mode),
      .count_load  (count_load),
      .count_value (count_value));

   sync_fifo #(.DEPTH(FPC_DEPTH)) fpc_fifo_i
     (.clock   (clock),
      .reset   (reset),
      .wr_data (fpc_data),
      .wr_en   (fpc_write),
      .ready   (fpc_ready),
      .rd_data (fpc_head),
      .valid   (fpc_head_valid),
      .rd_en   (fpc_pop));

   fifo_app fifo_app_i
     (.clock       (clock),
      .reset       (reset),
      .count_mode  (count_mode),
      .count_load  (count_load),
      .count_value (count_value),
      .src_data    (fpc_head),
      .src_valid   (fpc_head_valid),
      .src_read    (fpc_pop),
      .out_data    (app_data),
      .out_write   (app_write),
      .out_ready   (app_ready),
      .led         (led));

   sync_fifo #(.DEPTH(TPC_DEPTH)) tpc_fifo_i
     (.clock   (clock),
      .reset   (reset),
      .wr_data (app_data),
      .wr_en   (app_write),
      .ready   (app_ready),
      .rd_data (tpc_data),
      .valid   (tpc_valid),
      .rd_en   (tpc_read));

endmodule

//--- tests/fifo_bridge_checker.sv
`timescale 1ns/1ns

// Reset and stream protocol checks on the bridge ports.
module fifo_bridge_checker
  (
   input logic              clock,
   input logic              reset,
   input logic              fpc_write,
   input logic              fpc_ready,
   input hififo_pkg::word_t tpc_data,
   input logic              tpc_valid,
   input logic              tpc_read
   );

   // Read by the testbench top for the final verdict.
   int failures = 0;

   task automatic record_failure(input string what);
      failures++;
      $error("%s", what);
   endtask

   reset_clears_valid : assert property (@(posedge clock) reset |=> !tpc_valid)
      else record_failure("tpc_valid high in the cycle after reset");

   write_needs_ready : assert property (@(posedge clock) disable iff (reset)
      fpc_write |-> fpc_ready)
      else record_failure("fpc_write high while fpc_ready is low");

   // A word leaves only when the host read it.
   valid_falls_on_read : assert property (@(posedge clock) disable iff (reset)
      $fell(tpc_valid) |-> $past(tpc_read))
      else record_failure("tpc_valid fell without a tpc_read");

   data_held_on_stall : assert property (@(posedge clock) disable iff (reset)
      tpc_valid && !tpc_read |=> $stable(tpc_data))
      else record_failure("tpc_data changed while waiting for tpc_read");

endmodule

bind fifo_bridge_top fifo_bridge_checker checker_i
  (.clock     (clock),
   .reset     (reset),
   .fpc_write (fpc_write),
   .fpc_ready (fpc_ready),
   .tpc_data  (tpc_data),
   .tpc_valid (tpc_valid),
   .tpc_read  (tpc_read));

//--- tests/tb_monitor.sv
`timescale 1ns/1ns

// Watches the bridge ports and compares the to-host stream with a model.
module tb_monitor
  (
   input  logic                   clock,
   input  logic                   reset,
   input  hififo_pkg::pio_write_t pio,
   input  hififo_pkg::word_t      fpc_data,
   input  logic                   fpc_write,
   input  logic                   fpc_ready,
   input  hififo_pkg::word_t      tpc_data,
   input  logic                   tpc_valid,
   input  logic                   tpc_read,
   input  logic [3:0]             led,
   input  logic                   compare_on,
   input  logic                   count_check,
   input  logic                   led_check,
   input  logic                   test_end,
   input  logic                   run_end,
   input  int                     test_id,
   input  int                     other_fails,
   output int                     mismatches
   );

   import hififo_pkg::*;

   word_t      fpc_model [$];
   word_t      count_model;
   word_t      expected;
   logic [3:0] led_model;
   int         checked;
   int         test_checked;
   int         tests_run;
   int         tests_failed;
   int         mark;

   function automatic string test_name(input int id);
      case (id)
         1:       return "reset state";
         2:       return "counting";
         3:       return "ignored addresses";
         4:       return "loopback order";
         5:       return "led";
         6:       return "hold in count mode";
         default: return "unknown";
      endcase
   endfunction

   // One to-host word, either the next count or the oldest from-host word.
   task automatic check_word();
      if (count_check)
      begin
         expected = count_model;
         count_model = count_model + 64'd1;
      end
      else if (fpc_model.size() == 0)
      begin
         $display("to-host word %h arrived with no from-host word left to loop", tpc_data);
         mismatches++;
         return;
      end
      else
      begin
         expected = fpc_model.pop_front();
         led_model = expected[3:0];
      end
      checked++;
      test_checked++;
      if (tpc_data !== expected)
      begin
         $display("mismatch tpc_data: expected %h, actual %h", expected, tpc_data);
         mismatches++;
      end
   endtask

   task automatic report_test();
      int errors;
      errors = mismatches + other_fails - mark;
      tests_run++;
      if (errors != 0)
         tests_failed++;
      $display("test %0d %s: %s, %0d words checked, %0d errors", test_id,
               test_name(test_id), (errors == 0) ? "ok" : "failed", test_checked, errors);
      mark = mismatches + other_fails;
      test_checked = 0;
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Sampling on the rising edge
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always @(posedge clock)
   begin
      if (reset)
      begin
         fpc_model.delete();
         count_model = '0;
         led_model = LED_RESET;
         mismatches = 0;
         checked = 0;
         test_checked = 0;
         tests_run = 0;
         tests_failed = 0;
         mark = 0;
      end
      else
      begin
         if (pio.valid && pio.address == REG_COUNT_LOAD)
            count_model = pio.data;
         // Every accepted word is kept, whatever the mode.
         if (fpc_write && fpc_ready)
            fpc_model.push_back(fpc_data);
         if (tpc_valid && tpc_read && compare_on)
            check_word();
         if (led_check && led !== led_model)
         begin
            $display("mismatch led: expected %h, actual %h", led_model, led);
            mismatches++;
         end
         if (test_end)
            report_test();
         if (run_end)
            $display("%0d tests, %0d failed, %0d words checked, %0d mismatches, %0d other",
                     tests_run, tests_failed, checked, mismatches, other_fails);
      end
   end

endmodule

//--- tests/tb_top.sv
`timescale 1ns/1ns

module tb_top;

   import hififo_pkg::*;

   logic        clock;
   logic        reset;
   pio_write_t  pio;
   word_t       fpc_data;
   logic        fpc_write;
   logic        fpc_ready;
   word_t       tpc_data;
   logic        tpc_valid;
   logic        tpc_read;
   logic [3:0]  led;
   // Monitor control.
   logic        compare_on;
   logic        count_check;
   logic        led_check;
   logic        test_end;
   logic        run_end;
   int          test_id;
   int          tb_fails;
   int          other_fails;
   int          mismatches;
   int          seed;
   int          timer;
   int          pushes;
   int          low;
   logic [12:0] addr_pick;

   assign other_fails = tb_fails + dut_i.checker_i.failures;

   fifo_bridge_top dut_i (.*);

   tb_monitor mon_i (.*);

   initial
   begin
      clock = 1'b0;
      forever
         #10 clock = ~clock;
   end

   task automatic timed_out(input string what);
      $display("timeout while waiting for %s", what);
      tb_fails++;
   endtask

   task automatic expect_bit(input string name, input logic actual, input logic expected);
      if (actual !== expected)
      begin
         $display("mismatch %s: expected %h, actual %h", name, expected, actual);
         tb_fails++;
      end
   endtask

   task automatic host_write(input logic [12:0] address, input word_t data);
      @(negedge clock);
      pio.valid = 1'b1;
      pio.address = address;
      pio.data = data;
      @(negedge clock);
      pio.valid = 1'b0;
   endtask

   // Read until the to-host side has stayed empty for four cycles.
   task automatic drain();
      int idle;
      idle = 0;
      timer = 0;
      while (idle < 4 && timer < 200)
      begin
         @(negedge clock);
         tpc_read = 1'b1;
         idle = tpc_valid ? 0 : idle + 1;
         timer++;
      end
      tpc_read = 1'b0;
      if (idle < 4)
         timed_out("the to-host stream to drain");
   endtask

   // Random pushes and reads until n_read words have been taken.
   task automatic traffic(input int n_push, input int n_read, input string what);
      int sent;
      int got;
      sent = 0;
      got = 0;
      timer = 0;
      while (got < n_read && timer < 5000)
      begin
         @(negedge clock);
         fpc_write = (sent < n_push) && fpc_ready && ($random(seed) & 1);
         fpc_data = {$random(seed), $random(seed)};
         tpc_read = ($random(seed) & 3) != 0;
         if (fpc_write)
            sent++;
         if (tpc_read && tpc_valid)
            got++;
         timer++;
      end
      @(negedge clock);
      fpc_write = 1'b0;
      tpc_read = 1'b0;
      if (got < n_read)
         timed_out(what);
   endtask

   task automatic check_led();
      @(negedge clock);
      led_check = 1'b1;
      @(negedge clock);
      led_check = 1'b0;
   endtask

   task automatic end_test();
      @(negedge clock);
      test_end = 1'b1;
      @(negedge clock);
      test_end = 1'b0;
      test_id++;
   endtask

   initial
   begin
      seed = 80955;
      reset = 1'b1;
      pio = '0;
      fpc_data = '0;
      fpc_write = 1'b0;
      tpc_read = 1'b0;
      compare_on = 1'b0;
      count_check = 1'b0;
      led_check = 1'b0;
      test_end = 1'b0;
      run_end = 1'b0;
      test_id = 1;
      tb_fails = 0;
      repeat (8) @(negedge clock);
      reset = 1'b0;

      expect_bit("tpc_valid", tpc_valid, 1'b0);
      expect_bit("fpc_ready", fpc_ready, 1'b1);
      check_led();
      end_test();

      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      // Counter from a random start value
      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      host_write(REG_MODE, 64'd0);
      drain();
      host_write(REG_COUNT_LOAD, {$random(seed), $random(seed)});
      host_write(REG_MODE, 64'd1);
      compare_on = 1'b1;
      count_check = 1'b1;
      traffic(0, 40, "counter words");
      end_test();

      // Writes outside the map, then the count goes on.
      for (int i = 0; i < 20; i++)
      begin
         addr_pick = 13'($random(seed));
         if (addr_pick == REG_COUNT_LOAD || addr_pick == REG_MODE)
            addr_pick = addr_pick + 13'd2;
         host_write(addr_pick, {$random(seed), $random(seed)});
      end
      traffic(0, 40, "counter words after ignored writes");
      end_test();

      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      // Loopback and LED
      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      compare_on = 1'b0;
      host_write(REG_MODE, 64'd0);
      drain();
      compare_on = 1'b1;
      count_check = 1'b0;
      traffic(100, 100, "looped words");
      end_test();
      check_led();
      end_test();

      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      // From-host words held in count mode
      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      compare_on = 1'b0;
      host_write(REG_MODE, 64'd1);
      repeat (3) @(negedge clock);
      pushes = 0;
      low = 0;
      timer = 0;
      while (low < 4 && timer < 200)
      begin
         @(negedge clock);
         fpc_write = fpc_ready;
         fpc_data = {$random(seed), $random(seed)};
         pushes = fpc_ready ? pushes + 1 : pushes;
         low = fpc_ready ? 0 : low + 1;
         timer++;
      end
      fpc_write = 1'b0;
      if (low < 4)
         timed_out("fpc_ready to stay low");
      if (pushes != FPC_DEPTH)
      begin
         $display("count mode took %0d from-host words instead of %0d", pushes, FPC_DEPTH);
         tb_fails++;
      end
      host_write(REG_MODE, 64'd0);
      // Output register plus a full to-host FIFO of counter words.
      traffic(0, TPC_DEPTH + 1, "queued counter words");
      compare_on = 1'b1;
      traffic(0, FPC_DEPTH, "held words");
      check_led();
      end_test();

      @(negedge clock);
      run_end = 1'b1;
      @(negedge clock);
      run_end = 1'b0;
      if (mismatches == 0 && other_fails == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

//--- compile.f
hw/hififo_pkg.sv
hw/sync_fifo.sv
hw/pio_regs.sv
hw/fifo_app.sv
hw/fifo_bridge_top.sv
tests/fifo_bridge_checker.sv
tests/tb_monitor.sv
tests/tb_top.sv

//--- Bender.yml
package:
  name: fifo_bridge

sources:
  - files:
      - hw/hififo_pkg.sv
      - hw/sync_fifo.sv
      - hw/pio_regs.sv
      - hw/fifo_app.sv
      - hw/fifo_bridge_top.sv
  - target: test
    files:
      - tests/fifo_bridge_checker.sv
      - tests/tb_monitor.sv
      - tests/tb_top.sv
